//--- Bender.yml
package:
  name: cluster_mem

export_include_dirs:
  - rtl

sources:
  - rtl/cluster_pkg.sv
  - rtl/inflight_tracker.sv
  - rtl/mem_req_arb.sv
  - rtl/mem_rsp_route.sv
  - rtl/cluster_mem_top.sv
  - target: test
    files:
      - dv/tb_mem_model.sv
      - dv/tb_cluster_mem.sv

//--- dv/tb_cluster_mem.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module tb_cluster_mem;

    localparam int TABLE_LEN       = 8;
    localparam int N               = `CL_NUM_SOURCES;
    localparam int WATCHDOG_CYCLES = TABLE_LEN * 40 + 2000;

    typedef struct packed {
        cluster_pkg::src_id_t  src;
        cluster_pkg::cli_req_t req;
        cluster_pkg::data_t    exp;
    } stim_t;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  hold_rsp;
    logic [N-1:0]                          cli_req;
    cluster_pkg::cli_req_t [N-1:0]         cli_req_data;
    logic [N-1:0]                          cli_req_ack;
    logic                                  mem_req;
    cluster_pkg::mem_req_t                 mem_req_data;
    logic                                  mem_req_ack;
    logic                                  mem_rsp;
    cluster_pkg::mem_rsp_t                 mem_rsp_data;
    logic                                  mem_rsp_ack;
    logic [N-1:0]                          cli_rsp;
    cluster_pkg::cli_rsp_t [N-1:0]         cli_rsp_data;
    logic [N-1:0]                          cli_rsp_ack;
    logic                                  busy;

    stim_t                  stim_table [TABLE_LEN];
    cluster_pkg::mem_tag_t  mem_log [$];
    cluster_pkg::cli_rsp_t  last_rsp [N];
    int                     rsp_count [N];
    int                     req_count [N];
    int                     accepted;
    int                     checks;
    int                     errors;
    logic [31:0]            rng_state;

    cluster_mem_top UUT (.*);

    tb_mem_model mem_model (.hold(hold_rsp), .*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // Requests accepted at the memory port
    always @(negedge clk) begin
        if (rst_n && mem_req && !mem_req_ack) begin
            mem_log.push_back(mem_req_data.tag);
            accepted <= accepted + 1;
        end
    end

    // Client side of the response channels
    always @(negedge clk) begin
        for (int s = 0; s < N; s++) begin
            if (cli_rsp[s] && !cli_rsp_ack[s]) begin
                last_rsp[s]    <= cli_rsp_data[s];
                rsp_count[s]   <= rsp_count[s] + 1;
                cli_rsp_ack[s] <= 1'b1;
            end else if (!cli_rsp[s] && cli_rsp_ack[s]) begin
                cli_rsp_ack[s] <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cluster_pkg::cli_req_t make_req(input logic wr, input logic [31:0] addr,
                                                       input logic [31:0] data,
                                                       input logic [3:0] tag);
        cluster_pkg::cli_req_t r;
        r.wr   = wr;
        r.addr = addr;
        r.data = data;
        r.tag  = tag;
        return r;
    endfunction

    function automatic int count_diff();
        int d;
        d = 0;
        for (int s = 0; s < N; s++) begin
            d += req_count[s] - rsp_count[s];
        end
        return d;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    // Four-phase request from one client
    task automatic send_request(input int src, input cluster_pkg::cli_req_t req);
        @(negedge clk);
        cli_req_data[src] = req;
        cli_req[src]      = 1'b1;
        req_count[src]++;
        @(negedge clk);
        while (!cli_req_ack[src]) @(negedge clk);
        cli_req[src] = 1'b0;
        while (cli_req_ack[src]) @(negedge clk);
    endtask

    // Write then read back per source in a mixed source order
    task automatic build_table();
        int s;
        for (int k = 0; k < TABLE_LEN / 2; k++) begin
            s = (k * 3 + 1) % N;
            rng_state = xorshift32(rng_state);
            stim_table[2*k].src     = cluster_pkg::src_id_t'(s);
            stim_table[2*k].req     = make_req(1'b1, 32'h40 * (k + 1), rng_state, 4'(k * 4 + 1));
            stim_table[2*k].exp     = '0;
            stim_table[2*k+1].src   = cluster_pkg::src_id_t'(s);
            stim_table[2*k+1].req   = make_req(1'b0, 32'h40 * (k + 1), '0, 4'(k * 4 + 2));
            stim_table[2*k+1].exp   = rng_state;
        end
    endtask

    // All sources request at once with grants expected from first onward
    task automatic run_round(input int first);
        int base;
        cluster_pkg::cli_req_t reqs [N];
        base = mem_log.size();
        for (int s = 0; s < N; s++) begin
            rng_state = xorshift32(rng_state);
            reqs[s] = make_req(1'b1, 32'h200 + s * 4, rng_state, 4'(s + 8));
        end
        fork
            send_request(0, reqs[0]);
            send_request(1, reqs[1]);
            send_request(2, reqs[2]);
            send_request(3, reqs[3]);
        join
        for (int i = 0; i < N; i++) begin
            check_value($sformatf("round grant %0d", i), (first + i) % N,
                        mem_log[base + i] >> `CL_SRC_TAG_W);
        end
        while (count_diff() != 0) @(negedge clk);
    endtask

    initial begin
        int src;
        int base_src;
        int base_acc;
        cli_req      = '0;
        cli_req_data = '0;
        cli_rsp_ack  = '0;
        hold_rsp     = 1'b0;
        rst_n        = 1'b0;
        accepted     = 0;
        checks       = 0;
        errors       = 0;
        rng_state    = 32'h6761_6a2e;
        for (int s = 0; s < N; s++) begin
            rsp_count[s] = 0;
            req_count[s] = 0;
        end
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("idle after reset", '0, {busy, mem_req, mem_rsp_ack, cli_req_ack, cli_rsp});
        run_round(0);

        for (int i = 0; i < TABLE_LEN; i++) begin
            src      = stim_table[i].src;
            base_src = rsp_count[src];
            send_request(src, stim_table[i].req);
            check_value($sformatf("entry %0d mem tag", i), {stim_table[i].src,
                        stim_table[i].req.tag}, mem_log[mem_log.size() - 1]);
            while (rsp_count[src] == base_src) @(negedge clk);
            @(negedge clk);
            // Nothing else may have landed on any channel
            check_value($sformatf("entry %0d responses", i), 0, count_diff());
            check_value($sformatf("entry %0d rsp tag", i), stim_table[i].req.tag,
                        last_rsp[src].tag);
            check_value($sformatf("entry %0d rsp data", i), stim_table[i].exp,
                        last_rsp[src].data);
        end
        run_round((stim_table[TABLE_LEN - 1].src + 1) % N);

        // Fill the in-flight limit with responses held back
        base_acc = accepted;
        hold_rsp = 1'b1;
        for (int i = 0; i < `CL_MAX_INFLIGHT; i++) begin
            rng_state = xorshift32(rng_state);
            send_request(i % N, make_req(1'b1, 32'h300 + i * 4, rng_state, 4'(i)));
        end
        check_value("limit accepted", base_acc + `CL_MAX_INFLIGHT, accepted);
        fork
            send_request(0, make_req(1'b1, 32'h380, 32'h1234_5678, 4'he));
            send_request(1, make_req(1'b1, 32'h384, 32'h8765_4321, 4'hf));
        join_none
        repeat (20) @(negedge clk);
        check_value("stall at limit", base_acc + `CL_MAX_INFLIGHT, accepted);
        check_value("busy at limit", 1, busy);
        mem_model.release_one();
        while (accepted == base_acc + `CL_MAX_INFLIGHT) @(negedge clk);
        repeat (20) @(negedge clk);
        check_value("one more after release", base_acc + `CL_MAX_INFLIGHT + 1, accepted);
        check_value("busy after release", 1, busy);
        hold_rsp = 1'b0;
        wait fork;
        while (count_diff() != 0) @(negedge clk);
        // Last retire reaches the counter two cycles after the client ack
        repeat (4) @(negedge clk);
        check_value("busy drained", 0, busy);
        for (int s = 0; s < N; s++) begin
            check_value($sformatf("source %0d responses", s), req_count[s], rsp_count[s]);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/tb_mem_model.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module tb_mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold,
    input  logic                  mem_req,
    input  cluster_pkg::mem_req_t mem_req_data,
    output logic                  mem_req_ack,
    output logic                  mem_rsp,
    output cluster_pkg::mem_rsp_t mem_rsp_data,
    input  logic                  mem_rsp_ack
);

    cluster_pkg::data_t    mem [256];
    cluster_pkg::mem_rsp_t pending [$];
    cluster_pkg::mem_rsp_t rsp;
    int                    credits;

    initial begin
        mem_req_ack  = 1'b0;
        mem_rsp      = 1'b0;
        mem_rsp_data = '0;
        credits      = 0;
    end

    // Lets one queued response out while hold is set
    task automatic release_one();
        credits++;
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            mem_req_ack <= 1'b0;
            mem_rsp     <= 1'b0;
            pending.delete();
        end else begin
            if (mem_req && !mem_req_ack) begin
                rsp.tag = mem_req_data.tag;
                if (mem_req_data.wr) begin
                    mem[mem_req_data.addr[9:2]] = mem_req_data.data;
                    rsp.data = '0;
                end else begin
                    rsp.data = mem[mem_req_data.addr[9:2]];
                end
                pending.push_back(rsp);
                mem_req_ack <= 1'b1;
            end else if (!mem_req && mem_req_ack) begin
                mem_req_ack <= 1'b0;
            end
            // Next response only after the previous ack has dropped
            if (mem_rsp && mem_rsp_ack) begin
                mem_rsp <= 1'b0;
            end else if (!mem_rsp && !mem_rsp_ack && pending.size() > 0 &&
                         (!hold || credits > 0)) begin
                mem_rsp_data <= pending.pop_front();
                mem_rsp      <= 1'b1;
                if (hold) begin
                    credits--;
                end
            end
        end
    end

endmodule

//--- rtl/cluster_macros.svh
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Client caches sharing the memory port
`define CL_NUM_SOURCES   4
`define CL_SRC_ID_W      2

// Memory tag carries the source index above the local tag
`define CL_SRC_TAG_W     4
`define CL_MEM_TAG_W     (`CL_SRC_ID_W + `CL_SRC_TAG_W)

// Payload widths
`define CL_ADDR_W        32
`define CL_DATA_W        32

// Outstanding request limit and counter width
`define CL_MAX_INFLIGHT  8
`define CL_CNT_W         4

`endif

//--- rtl/cluster_mem_top.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module cluster_mem_top (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // Client request channels
    input  logic [`CL_NUM_SOURCES-1:0]                        cli_req,
    input  cluster_pkg::cli_req_t [`CL_NUM_SOURCES-1:0]       cli_req_data,
    output logic [`CL_NUM_SOURCES-1:0]                        cli_req_ack,

    // Memory request port
    output logic                                              mem_req,
    output cluster_pkg::mem_req_t                             mem_req_data,
    input  logic                                              mem_req_ack,

    // Memory response port
    input  logic                                              mem_rsp,
    input  cluster_pkg::mem_rsp_t                             mem_rsp_data,
    output logic                                              mem_rsp_ack,

    // Client response channels
    output logic [`CL_NUM_SOURCES-1:0]                        cli_rsp,
    output cluster_pkg::cli_rsp_t [`CL_NUM_SOURCES-1:0]       cli_rsp_data,
    input  logic [`CL_NUM_SOURCES-1:0]                        cli_rsp_ack,

    // Status
    output logic                                              busy
);

    logic issue;
    logic retire;
    logic at_limit;

    mem_req_arb u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .cli_req      (cli_req),
        .cli_req_data (cli_req_data),
        .cli_req_ack  (cli_req_ack),
        .mem_req      (mem_req),
        .mem_req_data (mem_req_data),
        .mem_req_ack  (mem_req_ack),
        .at_limit     (at_limit),
        .issue        (issue)
    );

    mem_rsp_route u_route (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_rsp      (mem_rsp),
        .mem_rsp_data (mem_rsp_data),
        .mem_rsp_ack  (mem_rsp_ack),
        .cli_rsp      (cli_rsp),
        .cli_rsp_data (cli_rsp_data),
        .cli_rsp_ack  (cli_rsp_ack),
        .retire       (retire)
    );

    // Outstanding count gates the arbiter and drives busy
    inflight_tracker u_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .retire       (retire),
        .at_limit     (at_limit),
        .busy         (busy)
    );

endmodule

//--- rtl/cluster_pkg.sv
`include "cluster_macros.svh"

package cluster_pkg;

    typedef logic [`CL_ADDR_W-1:0]    addr_t;
    typedef logic [`CL_DATA_W-1:0]    data_t;
    typedef logic [`CL_SRC_ID_W-1:0]  src_id_t;
    typedef logic [`CL_SRC_TAG_W-1:0] src_tag_t;
    typedef logic [`CL_MEM_TAG_W-1:0] mem_tag_t;

    typedef struct packed {
        logic     wr;
        addr_t    addr;
        data_t    data;
        src_tag_t tag;
    } cli_req_t;

    typedef struct packed {
        data_t    data;
        src_tag_t tag;
    } cli_rsp_t;

    typedef struct packed {
        logic     wr;
        addr_t    addr;
        data_t    data;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_MEM_REQ,
        ARB_MEM_REL,
        ARB_CLI_ACK
    } arb_state_t;

endpackage

//--- rtl/inflight_tracker.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module inflight_tracker (
    input  logic clk,
    input  logic rst_n,
    input  logic issue,
    input  logic retire,
    output logic at_limit,
    output logic busy
);

    logic [`CL_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({issue, retire})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                // Both or neither leave the count unchanged
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    assign at_limit = (count == `CL_CNT_W'(`CL_MAX_INFLIGHT));
    assign busy     = |count;

    property p_no_retire_at_zero;
        @(posedge clk) disable iff (!rst_n)
            retire && !issue |-> count != '0;
    endproperty

    a_no_retire_at_zero: assert property (p_no_retire_at_zero)
        else $error("retire with no request in flight");

    // Arbiter must have stalled before this point
    property p_no_issue_at_limit;
        @(posedge clk) disable iff (!rst_n)
            issue |-> !at_limit;
    endproperty

    a_no_issue_at_limit: assert property (p_no_issue_at_limit)
        else $error("issue beyond the in-flight limit");

endmodule

//--- rtl/mem_req_arb.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module mem_req_arb (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // Client request channels
    input  logic [`CL_NUM_SOURCES-1:0]                        cli_req,
    input  cluster_pkg::cli_req_t [`CL_NUM_SOURCES-1:0]       cli_req_data,
    output logic [`CL_NUM_SOURCES-1:0]                        cli_req_ack,

    // Memory request port
    output logic                                              mem_req,
    output cluster_pkg::mem_req_t                             mem_req_data,
    input  logic                                              mem_req_ack,

    // Tracker
    input  logic                                              at_limit,
    output logic                                              issue
);

    cluster_pkg::arb_state_t state;

    // Last granted source and owner of the transfer in progress
    cluster_pkg::src_id_t    grant_q;
    cluster_pkg::src_id_t    grant_idx;
    logic                    grant_found;
    logic                    take;

    // Round robin search starting just after the last grant
    always_comb begin
        grant_idx   = grant_q;
        grant_found = 1'b0;
        for (int i = 1; i <= `CL_NUM_SOURCES; i++) begin
            if (!grant_found && cli_req[(int'(grant_q) + i) % `CL_NUM_SOURCES]) begin
                grant_idx   = cluster_pkg::src_id_t'((int'(grant_q) + i) % `CL_NUM_SOURCES);
                grant_found = 1'b1;
            end
        end
    end

    assign take = (state == cluster_pkg::ARB_IDLE) && grant_found && !at_limit;

    // Payload capture with the source index placed above the local tag
    always_ff @(posedge clk) begin
        if (take) begin
            mem_req_data.wr   <= cli_req_data[grant_idx].wr;
            mem_req_data.addr <= cli_req_data[grant_idx].addr;
            mem_req_data.data <= cli_req_data[grant_idx].data;
            mem_req_data.tag  <= {grant_idx, cli_req_data[grant_idx].tag};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= cluster_pkg::ARB_IDLE;
            grant_q     <= cluster_pkg::src_id_t'(`CL_NUM_SOURCES - 1);
            mem_req     <= 1'b0;
            cli_req_ack <= '0;
            issue       <= 1'b0;
        end else begin
            issue <= 1'b0;
            case (state)
                cluster_pkg::ARB_IDLE: begin
                    if (take) begin
                        grant_q <= grant_idx;
                        mem_req <= 1'b1;
                        state   <= cluster_pkg::ARB_MEM_REQ;
                    end
                end
                cluster_pkg::ARB_MEM_REQ: begin
                    if (mem_req_ack) begin
                        mem_req <= 1'b0;
                        issue   <= 1'b1;
                        state   <= cluster_pkg::ARB_MEM_REL;
                    end
                end
                cluster_pkg::ARB_MEM_REL: begin
                    // Client released once the memory side has closed
                    if (!mem_req_ack) begin
                        cli_req_ack[grant_q] <= 1'b1;
                        state                <= cluster_pkg::ARB_CLI_ACK;
                    end
                end
                cluster_pkg::ARB_CLI_ACK: begin
                    if (!cli_req[grant_q]) begin
                        cli_req_ack <= '0;
                        state       <= cluster_pkg::ARB_IDLE;
                    end
                end
                default: begin
                    state <= cluster_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    property p_mem_req_stable;
        @(posedge clk) disable iff (!rst_n)
            mem_req && $past(mem_req) |-> $stable(mem_req_data);
    endproperty

    a_mem_req_stable: assert property (p_mem_req_stable)
        else $error("mem_req_data changed while mem_req was high");

    property p_single_cli_ack;
        @(posedge clk) disable iff (!rst_n)
            $onehot0(cli_req_ack);
    endproperty

    a_single_cli_ack: assert property (p_single_cli_ack)
        else $error("more than one cli_req_ack high");

endmodule

//--- rtl/mem_rsp_route.sv
`timescale 1ns/10ps
`include "cluster_macros.svh"

module mem_rsp_route (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // Memory response port
    input  logic                                              mem_rsp,
    input  cluster_pkg::mem_rsp_t                             mem_rsp_data,
    output logic                                              mem_rsp_ack,

    // Client response channels
    output logic [`CL_NUM_SOURCES-1:0]                        cli_rsp,
    output cluster_pkg::cli_rsp_t [`CL_NUM_SOURCES-1:0]       cli_rsp_data,
    input  logic [`CL_NUM_SOURCES-1:0]                        cli_rsp_ack,

    // Tracker
    output logic                                              retire
);

    typedef enum logic [1:0] {
        RT_IDLE,
        RT_MEM_ACK,
        RT_CLI_RSP,
        RT_CLI_REL
    } rt_state_t;

    rt_state_t             state;
    cluster_pkg::mem_rsp_t rsp_q;
    cluster_pkg::src_id_t  rsp_src;

    // Source index sits in the top bits of the memory tag
    assign rsp_src = rsp_q.tag[`CL_MEM_TAG_W-1 -: `CL_SRC_ID_W];

    always_ff @(posedge clk) begin
        if (state == RT_IDLE && mem_rsp) begin
            rsp_q <= mem_rsp_data;
        end
    end

    // Only the addressed source sees the payload
    always_comb begin
        for (int i = 0; i < `CL_NUM_SOURCES; i++) begin
            cli_rsp_data[i] = '0;
            if (rsp_src == cluster_pkg::src_id_t'(i)) begin
                cli_rsp_data[i].data = rsp_q.data;
                cli_rsp_data[i].tag  = rsp_q.tag[`CL_SRC_TAG_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RT_IDLE;
            mem_rsp_ack <= 1'b0;
            cli_rsp     <= '0;
            retire      <= 1'b0;
        end else begin
            retire <= 1'b0;
            case (state)
                RT_IDLE: begin
                    if (mem_rsp) begin
                        mem_rsp_ack <= 1'b1;
                        state       <= RT_MEM_ACK;
                    end
                end
                RT_MEM_ACK: begin
                    if (!mem_rsp) begin
                        mem_rsp_ack      <= 1'b0;
                        cli_rsp[rsp_src] <= 1'b1;
                        state            <= RT_CLI_RSP;
                    end
                end
                RT_CLI_RSP: begin
                    if (cli_rsp_ack[rsp_src]) begin
                        cli_rsp <= '0;
                        state   <= RT_CLI_REL;
                    end
                end
                RT_CLI_REL: begin
                    // Response is complete once the client drops its ack
                    if (!cli_rsp_ack[rsp_src]) begin
                        retire <= 1'b1;
                        state  <= RT_IDLE;
                    end
                end
                default: begin
                    state <= RT_IDLE;
                end
            endcase
        end
    end

    property p_single_cli_rsp;
        @(posedge clk) disable iff (!rst_n)
            $onehot0(cli_rsp);
    endproperty

    a_single_cli_rsp: assert property (p_single_cli_rsp)
        else $error("more than one cli_rsp high");

endmodule

//--- sim.f
+incdir+rtl
rtl/cluster_pkg.sv
rtl/inflight_tracker.sv
rtl/mem_req_arb.sv
rtl/mem_rsp_route.sv
rtl/cluster_mem_top.sv
dv/tb_mem_model.sv
dv/tb_cluster_mem.sv
